// ==== Makefile ====
TOP := tb_dual_issue

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run $(TOP)"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f dual_issue.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== dual_issue.f ====
+incdir+test
hdl/issue_pkg.sv
hdl/pair_decoder.sv
hdl/issue_dispatcher.sv
hdl/exec_lane.sv
hdl/result_commit.sv
hdl/dual_issue_top.sv
test/tb_dual_issue.sv

// ==== hdl/dual_issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_issue_top
    import issue_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    fetch_req,
    input  pair_t   fetch_pair,
    output logic    fetch_ack,
    output commit_t commit0,
    output commit_t commit1
);

    uop_t                  slot0;
    uop_t                  slot1;
    logic                  take0;
    logic                  take1;
    reg_idx_t [NUM_RD-1:0] rd_idx;
    word_t    [NUM_RD-1:0] rd_val;
    issue_t                issue0;
    issue_t                issue1;
    lane_res_t             e1_res0;
    lane_res_t             e1_res1;
    lane_res_t             e2_res0;
    lane_res_t             e2_res1;

    pair_decoder u_decoder (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_req  (fetch_req),
        .fetch_pair (fetch_pair),
        .fetch_ack  (fetch_ack),
        .take0      (take0),
        .take1      (take1),
        .slot0      (slot0),
        .slot1      (slot1)
    );

    issue_dispatcher u_dispatcher (
        .slot0   (slot0),
        .slot1   (slot1),
        .take0   (take0),
        .take1   (take1),
        .rd_idx  (rd_idx),
        .rd_val  (rd_val),
        .e1_res0 (e1_res0),
        .e1_res1 (e1_res1),
        .e2_res0 (e2_res0),
        .e2_res1 (e2_res1),
        .issue0  (issue0),
        .issue1  (issue1)
    );

    // lane 0 owns the multiplier
    exec_lane #(.MUL_EN(1'b1)) u_lane0 (
        .clk    (clk),
        .rstn   (rstn),
        .issue  (issue0),
        .e1_res (e1_res0),
        .e2_res (e2_res0)
    );

    exec_lane #(.MUL_EN(1'b0)) u_lane1 (
        .clk    (clk),
        .rstn   (rstn),
        .issue  (issue1),
        .e1_res (e1_res1),
        .e2_res (e2_res1)
    );

    result_commit u_result (
        .clk     (clk),
        .rstn    (rstn),
        .e2_res0 (e2_res0),
        .e2_res1 (e2_res1),
        .rd_idx  (rd_idx),
        .rd_val  (rd_val),
        .commit0 (commit0),
        .commit1 (commit1)
    );

endmodule

`default_nettype wire

// ==== hdl/exec_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_lane
    import issue_pkg::*;
#(
    parameter bit MUL_EN = 1'b1
)(
    input  logic      clk,
    input  logic      rstn,
    input  issue_t    issue,
    output lane_res_t e1_res,
    output lane_res_t e2_res
);

    issue_t      s1;
    logic        s1_v;
    word_t       alu;
    logic        s1_mul;
    word_t       p_lo;
    logic [15:0] p_hi;
    lane_res_t   s2;
    logic        s2_v;
    word_t       s2_plo;
    logic [15:0] s2_phi;

    // stage 1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_v <= 1'b0;
            s2_v <= 1'b0;
        end else begin
            s1_v <= issue.valid;
            s2_v <= s1_v;
        end
    end

    always_ff @(posedge clk) begin
        s1 <= issue;
    end

    always_comb begin
        case (s1.opcode)
            OP_ADD:  alu = s1.a + s1.b;
            OP_SUB:  alu = s1.a - s1.b;
            OP_AND:  alu = s1.a & s1.b;
            OP_OR:   alu = s1.a | s1.b;
            OP_XOR:  alu = s1.a ^ s1.b;
            OP_SLL:  alu = s1.a << s1.b[4:0];
            OP_SRL:  alu = s1.a >> s1.b[4:0];
            OP_ADDI: alu = s1.a + s1.imm;
            OP_LUI:  alu = s1.imm << 20;
            default: alu = '0;
        endcase
    end

    assign s1_mul = MUL_EN && (s1.opcode == OP_MUL);

    // partial products here, summed in stage 2
    if (MUL_EN) begin : g_mul
        assign p_lo = s1.a * {16'h0000, s1.b[15:0]};
        assign p_hi = s1.a[15:0] * s1.b[31:16];
    end else begin : g_no_mul
        assign p_lo = '0;
        assign p_hi = '0;
    end

    assign e1_res = '{valid: s1_v, rd: s1.rd, value: alu, pc: s1.pc, is_mul: s1_mul};

    // stage 2
    always_ff @(posedge clk) begin
        s2     <= e1_res;
        s2_plo <= p_lo;
        s2_phi <= p_hi;
    end

    always_comb begin
        e2_res       = s2;
        e2_res.valid = s2_v;
        if (s2.is_mul) e2_res.value = s2_plo + {s2_phi, 16'h0000};
    end

endmodule

`default_nettype wire

// ==== hdl/issue_dispatcher.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_dispatcher
    import issue_pkg::*;
(
    input  uop_t                    slot0,
    input  uop_t                    slot1,
    output logic                    take0,
    output logic                    take1,
    output reg_idx_t [NUM_RD-1:0]   rd_idx,
    input  word_t    [NUM_RD-1:0]   rd_val,
    input  lane_res_t               e1_res0,
    input  lane_res_t               e1_res1,
    input  lane_res_t               e2_res0,
    input  lane_res_t               e2_res1,
    output issue_t                  issue0,
    output issue_t                  issue1
);

    logic  stall0;
    logic  stall1;
    logic  pair_ok;
    word_t a0;
    word_t b0;
    word_t a1;
    word_t b1;

    function automatic logic reads_rj(opcode_t op);
        return !(op inside {OP_NOP, OP_LUI});
    endfunction

    function automatic logic reads_rk(opcode_t op);
        return !(op inside {OP_NOP, OP_ADDI, OP_LUI});
    endfunction

    // r0 is never a real dependency
    function automatic logic uses(uop_t u, reg_idx_t r);
        return (r != '0) && ((reads_rj(u.opcode) && u.rj == r) ||
                             (reads_rk(u.opcode) && u.rk == r));
    endfunction

    function automatic logic waits_mul(uop_t u, lane_res_t r);
        return r.valid && r.is_mul && uses(u, r.rd);
    endfunction

    // youngest producer first since lane 1 is younger than lane 0
    function automatic word_t operand(reg_idx_t idx, word_t rf_val, lane_res_t s1_l0,
                                      lane_res_t s1_l1, lane_res_t s2_l0, lane_res_t s2_l1);
        if (idx == '0) return '0;
        if (s1_l1.valid && !s1_l1.is_mul && s1_l1.rd == idx) return s1_l1.value;
        if (s1_l0.valid && !s1_l0.is_mul && s1_l0.rd == idx) return s1_l0.value;
        if (s2_l1.valid && s2_l1.rd == idx) return s2_l1.value;
        if (s2_l0.valid && s2_l0.rd == idx) return s2_l0.value;
        return rf_val;
    endfunction

    function automatic issue_t build(uop_t u, word_t a, word_t b, logic go);
        issue_t r;
        r.valid  = go;
        r.opcode = u.opcode;
        r.rd     = u.rd;
        r.a      = a;
        r.b      = b;
        r.imm    = {{20{u.imm[11]}}, u.imm};
        r.pc     = u.pc;
        return r;
    endfunction

    assign rd_idx[0] = slot0.rj;
    assign rd_idx[1] = slot0.rk;
    assign rd_idx[2] = slot1.rj;
    assign rd_idx[3] = slot1.rk;

    assign a0 = operand(slot0.rj, rd_val[0], e1_res0, e1_res1, e2_res0, e2_res1);
    assign b0 = operand(slot0.rk, rd_val[1], e1_res0, e1_res1, e2_res0, e2_res1);
    assign a1 = operand(slot1.rj, rd_val[2], e1_res0, e1_res1, e2_res0, e2_res1);
    assign b1 = operand(slot1.rk, rd_val[3], e1_res0, e1_res1, e2_res0, e2_res1);

    // product not ready while the multiply sits in lane 0 stage 1
    assign stall0 = waits_mul(slot0, e1_res0);
    assign stall1 = waits_mul(slot1, e1_res0);

    // only lane 0 can multiply
    assign pair_ok = slot0.valid && slot1.valid && !uses(slot1, slot0.rd) &&
                     (slot1.opcode != OP_MUL);

    always_comb begin
        take0 = 1'b0;
        take1 = 1'b0;
        if (slot0.valid) begin
            if (!stall0 && !(pair_ok && stall1)) begin
                take0 = 1'b1;
                take1 = pair_ok;
            end
        end else if (slot1.valid && !stall1) begin
            take1 = 1'b1;
        end
    end

    // a lone younger slot goes to lane 0
    assign issue0 = take0 ? build(slot0, a0, b0, 1'b1) :
                            build(slot1, a1, b1, take1 && !slot0.valid);
    assign issue1 = build(slot1, a1, b1, take1 && slot0.valid);

endmodule

`default_nettype wire

// ==== hdl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // read ports between dispatcher and register file
    localparam int NUM_RD = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] imm_t;

    // instruction: op[31:28] rd[27:23] rj[22:18] rk[17:13] spare[12] imm[11:0]
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LUI  = 4'd9,
        OP_MUL  = 4'd10
    } opcode_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        imm_t     imm;
        word_t    pc;
    } uop_t;

    // one lane's record, operands already resolved
    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    pc;
    } issue_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
        word_t    pc;
        logic     is_mul;
    } lane_res_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

    // word1 sits at pc + 4
    typedef struct packed {
        word_t word0;
        word_t word1;
        word_t pc;
    } pair_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ACK,
        RX_HOLD
    } rx_state_t;

endpackage

`default_nettype wire

// ==== hdl/pair_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module pair_decoder
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  fetch_req,
    input  pair_t fetch_pair,
    output logic  fetch_ack,
    input  logic  take0,
    input  logic  take1,
    output uop_t  slot0,
    output uop_t  slot1
);

    rx_state_t state;
    logic      v0;
    logic      v1;
    uop_t      u0_q;
    uop_t      u1_q;
    logic      accept;

    function automatic uop_t decode(word_t w, word_t pc);
        uop_t u;
        u.valid = 1'b1;
        u.rd    = w[27:23];
        u.rj    = w[22:18];
        u.rk    = w[17:13];
        u.imm   = w[11:0];
        u.pc    = pc;
        case (w[31:28])
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SLL, OP_SRL, OP_ADDI, OP_LUI, OP_MUL: u.opcode = opcode_t'(w[31:28]);
            default: u.opcode = OP_NOP;
        endcase
        // nop still commits, but as a write to r0
        if (u.opcode == OP_NOP) begin
            u.rd = '0;
            u.rj = '0;
            u.rk = '0;
        end
        return u;
    endfunction

    // buffer must be fully drained before a new pair
    assign accept    = (state != RX_ACK) && fetch_req && !v0 && !v1;
    assign fetch_ack = (state == RX_ACK);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: if (fetch_req) state <= accept ? RX_ACK : RX_HOLD;
                RX_HOLD: if (accept) state <= RX_ACK;
                RX_ACK:  if (!fetch_req) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            v0 <= 1'b0;
            v1 <= 1'b0;
        end else if (accept) begin
            v0 <= 1'b1;
            v1 <= 1'b1;
        end else begin
            if (take0) v0 <= 1'b0;
            if (take1) v1 <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            u0_q <= decode(fetch_pair.word0, fetch_pair.pc);
            u1_q <= decode(fetch_pair.word1, fetch_pair.pc + 32'd4);
        end
    end

    always_comb begin
        slot0       = u0_q;
        slot0.valid = v0;
        slot1       = u1_q;
        slot1.valid = v1;
    end

endmodule

`default_nettype wire

// ==== hdl/result_commit.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_commit
    import issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  lane_res_t               e2_res0,
    input  lane_res_t               e2_res1,
    input  reg_idx_t [NUM_RD-1:0]   rd_idx,
    output word_t    [NUM_RD-1:0]   rd_val,
    output commit_t                 commit0,
    output commit_t                 commit1
);

    word_t rf [32];
    logic  wr0;
    logic  wr1;

    // r0 never written
    assign wr0 = e2_res0.valid && (e2_res0.rd != '0);
    assign wr1 = e2_res1.valid && (e2_res1.rd != '0);

    // architectural state starts at zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (wr0) rf[e2_res0.rd] <= e2_res0.value;
            // lane 1 is younger, so it lands last
            if (wr1) rf[e2_res1.rd] <= e2_res1.value;
        end
    end

    // write-through for results retiring this cycle
    always_comb begin
        for (int i = 0; i < NUM_RD; i++) begin
            if (rd_idx[i] == '0) begin
                rd_val[i] = '0;
            end else if (wr1 && e2_res1.rd == rd_idx[i]) begin
                rd_val[i] = e2_res1.value;
            end else if (wr0 && e2_res0.rd == rd_idx[i]) begin
                rd_val[i] = e2_res0.value;
            end else begin
                rd_val[i] = rf[rd_idx[i]];
            end
        end
    end

    // stage 2 is the commit cycle, lane 0 older
    always_comb begin
        commit0.valid = e2_res0.valid;
        commit0.pc    = e2_res0.pc;
        commit0.rd    = e2_res0.rd;
        commit0.value = wr0 ? e2_res0.value : '0;

        commit1.valid = e2_res1.valid;
        commit1.pc    = e2_res1.pc;
        commit1.rd    = e2_res1.rd;
        commit1.value = wr1 ? e2_res1.value : '0;
    end

endmodule

`default_nettype wire

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state of the model, zero after reset like the core
word_t   model_rf [32] = '{default: '0};
commit_t exp_q[$];

// runs the words in program order and queues the commit each one must produce
function automatic void predict_commits(input word_t words[$], input word_t base_pc);
    word_t    w;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    v;
    reg_idx_t rd;
    commit_t  c;
    for (int i = 0; i < words.size(); i++) begin
        w   = words[i];
        rd  = w[27:23];
        a   = model_rf[w[22:18]];
        b   = model_rf[w[17:13]];
        imm = {{20{w[11]}}, w[11:0]};
        case (w[31:28])
            OP_ADD:  v = a + b;
            OP_SUB:  v = a - b;
            OP_AND:  v = a & b;
            OP_OR:   v = a | b;
            OP_XOR:  v = a ^ b;
            OP_SLL:  v = a << b[4:0];
            OP_SRL:  v = a >> b[4:0];
            OP_ADDI: v = a + imm;
            OP_LUI:  v = {w[11:0], 20'h00000};
            OP_MUL:  v = a * b;
            // nop and undefined opcodes retire as a write to r0
            default: begin
                rd = 5'd0;
                v  = 32'd0;
            end
        endcase
        if (rd == 5'd0) begin
            v = 32'd0;
        end else begin
            model_rf[rd] = v;
        end
        c.valid = 1'b1;
        c.pc    = base_pc + 32'(i * 4);
        c.rd    = rd;
        c.value = v;
        exp_q.push_back(c);
    end
endfunction

task automatic check_commit(input string name, input commit_t exp, input commit_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected pc %h rd %0d value %h, actual pc %h rd %0d value %h",
                 name, exp.pc, exp.rd, exp.value, act.pc, act.rd, act.value);
    end
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

`endif

// ==== test/tb_dual_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dual_issue
    import issue_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_PROGS   = 2;
    localparam int RAND_LEN     = 200;
    localparam int TOTAL_INSTR  = 20 + RAND_PROGS * RAND_LEN;
    // handshake, stalls and drain of one pair stay well inside this
    localparam int PAIR_BOUND   = 20;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 40 + PAIR_BOUND * TOTAL_INSTR / 2) * CLK_PERIOD;

    logic    clk;
    logic    rstn;
    logic    fetch_req;
    pair_t   fetch_pair;
    logic    fetch_ack;
    commit_t commit0;
    commit_t commit1;

    int      errors;
    int      checks;
    int      tests_run;
    int      tests_failed;
    int      fails_at_start;
    int      cycle;
    string   test_name;
    word_t   next_pc;
    word_t   prog[$];
    commit_t act_q[$];
    int      commit_cyc[word_t];
    word_t   commit_val[word_t];

    `include "tb_ref_model.svh"

    dual_issue_top dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_req  (fetch_req),
        .fetch_pair (fetch_pair),
        .fetch_ack  (fetch_ack),
        .commit0    (commit0),
        .commit1    (commit1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // sampled mid-cycle with lane 0 first as the older commit
    initial begin
        forever begin
            @(negedge clk);
            if (rstn && commit0.valid) begin
                commit_cyc[commit0.pc] = cycle;
                commit_val[commit0.pc] = commit0.value;
                act_q.push_back(commit0);
            end
            if (rstn && commit1.valid) begin
                commit_cyc[commit1.pc] = cycle;
                commit_val[commit1.pc] = commit1.value;
                act_q.push_back(commit1);
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            while (act_q.size() != 0) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("commit at pc %h arrived with no instruction outstanding",
                             act_q[0].pc);
                    act_q.delete(0);
                end else begin
                    check_commit(test_name, exp_q.pop_front(), act_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    // op rd rj rk spare imm
    task automatic emit(input logic [3:0] op, input int rd, input int rj, input int rk,
                        input int imm);
        prog.push_back({op, rd[4:0], rj[4:0], rk[4:0], 1'b0, imm[11:0]});
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        fails_at_start = errors;
        prog.delete();
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == fails_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - fails_at_start);
        end
    endtask

    // four-phase handover started a little after a rising edge
    task automatic send_pair(input word_t w0, input word_t w1, input word_t pc);
        fetch_pair.word0 = w0;
        fetch_pair.word1 = w1;
        fetch_pair.pc    = pc;
        fetch_req        = 1'b1;
        @(posedge clk);
        #2;
        while (!fetch_ack) begin
            @(posedge clk);
            #2;
        end
        fetch_req = 1'b0;
        @(posedge clk);
        #2;
        while (fetch_ack) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_program();
        if (prog.size() % 2 != 0) prog.push_back(32'h0);
        predict_commits(prog, next_pc);
        for (int i = 0; i < prog.size(); i += 2) begin
            send_pair(prog[i], prog[i + 1], next_pc + 32'(i * 4));
        end
        next_pc = next_pc + 32'(prog.size() * 4);
        while (exp_q.size() != 0 || act_q.size() != 0) @(posedge clk);
        // a few more cycles to catch stray commits
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic random_program(input int n);
        logic [3:0] op;
        for (int i = 0; i < n; i++) begin
            op = 4'($urandom_range(0, 11));
            // 11 stands in for an undefined opcode
            if (op == 4'd11) op = 4'd14;
            emit(op, $urandom_range(0, 5), $urandom_range(0, 5), $urandom_range(0, 5),
                 $urandom);
        end
    endtask

    initial begin
        word_t base;
        void'($urandom(40));
        rstn         = 1'b0;
        fetch_req    = 1'b0;
        fetch_pair   = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        next_pc      = 32'h0000_1000;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;

        start_test("reset_state");
        repeat (4) begin
            @(posedge clk);
            #2;
            check_word("reset_state", 32'd0, {29'd0, fetch_ack, commit0.valid, commit1.valid});
        end
        finish_test();

        start_test("independent_pair");
        base = next_pc;
        emit(OP_ADDI, 1, 0, 0, 5);
        emit(OP_ADDI, 2, 0, 0, -7);
        emit(OP_ADD, 3, 1, 2, 0);
        emit(OP_XOR, 4, 2, 1, 0);
        run_program();
        check_word("independent_pair", 32'd1,
                   (commit_cyc[base] == commit_cyc[base + 4]) ? 32'd1 : 32'd0);
        check_word("independent_pair", 32'd1,
                   (commit_cyc[base + 8] == commit_cyc[base + 12]) ? 32'd1 : 32'd0);
        finish_test();

        start_test("dependent_pair");
        base = next_pc;
        emit(OP_ADDI, 5, 1, 0, 100);
        emit(OP_ADD, 6, 5, 5, 0);
        emit(OP_SUB, 7, 6, 5, 0);
        emit(OP_SLL, 8, 7, 2, 0);
        run_program();
        check_word("dependent_pair", 32'd1,
                   (commit_cyc[base + 4] > commit_cyc[base]) ? 32'd1 : 32'd0);
        finish_test();

        start_test("multiply_forwarding");
        emit(OP_LUI, 9, 0, 0, 'h123);
        emit(OP_ADDI, 13, 0, 0, 3);
        emit(OP_MUL, 10, 9, 2, 0);
        emit(OP_ADD, 11, 10, 1, 0);
        emit(OP_ADDI, 12, 10, 0, 3);
        emit(OP_MUL, 14, 10, 13, 0);
        emit(OP_SRL, 15, 14, 13, 0);
        emit(OP_OR, 16, 14, 11, 0);
        run_program();
        finish_test();

        start_test("register_r0");
        base = next_pc;
        emit(OP_ADDI, 0, 1, 0, 55);
        emit(OP_ADD, 17, 0, 1, 0);
        emit(OP_LUI, 0, 0, 0, 'hABC);
        emit(OP_OR, 18, 0, 0, 0);
        run_program();
        check_word("register_r0", 32'd0, commit_val[base]);
        check_word("register_r0", 32'd0, commit_val[base + 8]);
        finish_test();

        for (int p = 0; p < RAND_PROGS; p++) begin
            start_test($sformatf("random_%0d", p));
            random_program(RAND_LEN);
            run_program();
            finish_test();
        end

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
